// ==== renameCore_defs.svh ====
`ifndef RENAMECORE_DEFS_SVH
`define RENAMECORE_DEFS_SVH

// Architectural register file
`define REG_NUM   32
`define REG_W     5

// Tag 0 of the reorder buffer is reserved for "no pending producer"
`define ROB_DEPTH 7
`define TAG_W     3

// Datapath fields
`define DATA_W    32
`define ADDR_W    32
`define IMM_W     32
`define OP_W      6

`endif

// ==== archPkg.sv ====
`include "renameCore_defs.svh"

package archPkg;

    typedef logic [`REG_W-1:0]  regName;
    // Zero means the register holds its final value
    typedef logic [`TAG_W-1:0]  robTag;
    typedef logic [`DATA_W-1:0] dataWord;
    typedef logic [`ADDR_W-1:0] instAddr;
    typedef logic [`IMM_W-1:0]  immWord;

    // RV32I operation classes as delivered by decode
    typedef enum logic [`OP_W-1:0] {
        OP_NOP,
        OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } opCode;

endpackage

// ==== dispatchPkg.sv ====
package dispatchPkg;

    // One instruction as handed over by decode
    typedef struct packed {
        archPkg::opCode   op;
        archPkg::regName  rs1;
        archPkg::regName  rs2;
        archPkg::regName  rd;
        archPkg::instAddr pc;
        archPkg::immWord  imm;
        logic             predTaken;
    } decodedInst;

    // Decoded instruction plus its resolved operands and allocated tag
    typedef struct packed {
        decodedInst       inst;
        archPkg::dataWord rs1Data;
        archPkg::robTag   rs1Tag;
        archPkg::dataWord rs2Data;
        archPkg::robTag   rs2Tag;
        archPkg::robTag   tag;
        // Zero when nothing gets renamed
        archPkg::regName  dest;
    } dispatchPacket;

    typedef struct packed {
        archPkg::robTag   tag;
        archPkg::dataWord data;
    } resultMsg;

    typedef struct packed {
        archPkg::regName  dest;
        archPkg::robTag   tag;
        archPkg::dataWord data;
    } commitMsg;

endpackage

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "renameCore_defs.svh"

module regFile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      issueReq,
    input  dispatchPkg::decodedInst   issueInst,
    output logic                      issueAck,
    output logic                      dispatchValid,
    output dispatchPkg::dispatchPacket dispatch,
    input  logic                      robFull,
    input  archPkg::robTag            allocTag,
    output logic                      allocEn,
    output archPkg::regName           allocDest,
    input  logic                      commitValid,
    input  dispatchPkg::commitMsg     commit
);

    typedef enum logic {
        IDLE,
        ACKED
    } hsState;

    hsState state;

    archPkg::dataWord dataArr [`REG_NUM];
    archPkg::robTag   tagArr  [`REG_NUM];

    logic isStore;
    logic accept;

    assign isStore = (issueInst.op == archPkg::OP_SB) ||
                     (issueInst.op == archPkg::OP_SH) ||
                     (issueInst.op == archPkg::OP_SW);

    // Stores and x0 writers still take a ROB entry but rename nothing
    assign allocDest = (isStore || issueInst.rd == '0) ? '0 : issueInst.rd;

    // A request pending on the flush edge waits for the next cycle
    assign accept   = (state == IDLE) && issueReq && !robFull && !flush;
    assign allocEn  = accept;
    assign issueAck = (state == ACKED);

    // Four-phase handshake with decode
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (accept) state <= ACKED;
                ACKED:   if (!issueReq) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatchValid <= 1'b0;
        end else begin
            dispatchValid <= accept;
        end
    end

    // Operands are read from the table as it stood before this edge
    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch.inst    <= issueInst;
            dispatch.rs1Data <= dataArr[issueInst.rs1];
            dispatch.rs1Tag  <= tagArr[issueInst.rs1];
            dispatch.rs2Data <= dataArr[issueInst.rs2];
            dispatch.rs2Tag  <= tagArr[issueInst.rs2];
            dispatch.tag     <= allocTag;
            dispatch.dest    <= allocDest;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                dataArr[i] <= '0;
                tagArr[i]  <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                tagArr[i] <= '0;
            end
            // Every younger producer is squashed, so the retiring value is final
            if (commitValid && commit.dest != '0) begin
                dataArr[commit.dest] <= commit.data;
            end
        end else begin
            // Only the newest producer may clear the tag
            if (commitValid && commit.dest != '0 && tagArr[commit.dest] == commit.tag) begin
                dataArr[commit.dest] <= commit.data;
                tagArr[commit.dest]  <= '0;
            end
            // Comes last so a same-edge rename keeps its new tag
            if (allocEn && allocDest != '0) begin
                tagArr[allocDest] <= allocTag;
            end
        end
    end

    ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(issueAck) |-> $past(issueReq))
        else $error("issueAck rose without a pending issueReq");

endmodule

// ==== reorderBuffer.sv ====
`timescale 1ns/1ps
`include "renameCore_defs.svh"

module reorderBuffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  allocEn,
    input  archPkg::regName       allocDest,
    output archPkg::robTag        allocTag,
    output logic                  robFull,
    input  logic                  resultValid,
    input  dispatchPkg::resultMsg result,
    output logic                  commitValid,
    output dispatchPkg::commitMsg commit
);

    localparam int DEPTH = `ROB_DEPTH;

    typedef logic [`TAG_W-1:0] robIdx;

    logic             doneArr [DEPTH];
    archPkg::regName  destArr [DEPTH];
    archPkg::dataWord dataArr [DEPTH];

    robIdx head;
    robIdx tail;
    robIdx count;
    robIdx resIdx;
    logic  retire;

    function automatic robIdx nextIdx(robIdx p);
        return (p == robIdx'(DEPTH - 1)) ? '0 : p + robIdx'(1);
    endfunction

    // Entry i carries tag i+1 so that tag 0 stays free
    function automatic archPkg::robTag idxToTag(robIdx i);
        return archPkg::robTag'(i + 1);
    endfunction

    function automatic robIdx tagToIdx(archPkg::robTag t);
        return robIdx'(t - 1);
    endfunction

    function automatic logic isLive(robIdx idx);
        robIdx offset;
        offset = (idx >= head) ? idx - head : robIdx'(idx + DEPTH - head);
        return offset < count;
    endfunction

    assign allocTag = idxToTag(tail);
    assign robFull  = (count == robIdx'(DEPTH));
    assign resIdx   = tagToIdx(result.tag);
    assign retire   = (count != '0) && doneArr[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            commitValid <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                doneArr[i] <= 1'b0;
            end
        end else begin
            commitValid <= retire;
            if (retire) begin
                head <= nextIdx(head);
            end
            if (allocEn) begin
                tail          <= nextIdx(tail);
                doneArr[tail] <= 1'b0;
            end
            // A result never targets the entry being allocated
            if (resultValid) begin
                doneArr[resIdx] <= 1'b1;
            end
            count <= count + robIdx'(allocEn) - robIdx'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            destArr[tail] <= allocDest;
        end
        if (resultValid) begin
            dataArr[resIdx] <= result.data;
        end
        if (retire) begin
            commit.dest <= destArr[head];
            commit.tag  <= idxToTag(head);
            commit.data <= dataArr[head];
        end
    end

    noAllocWhenFull: assert property (@(posedge clk) disable iff (rst)
        allocEn |-> !robFull)
        else $error("allocation requested while the ROB is full");

    resultHitsLiveEntry: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> (result.tag != '0) && isLive(resIdx))
        else $error("result tag %0d names no occupied entry", result.tag);

endmodule

// ==== renameCore.sv ====
`timescale 1ns/1ps

module renameCore (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       issueReq,
    input  dispatchPkg::decodedInst    issueInst,
    output logic                       issueAck,
    output logic                       dispatchValid,
    output dispatchPkg::dispatchPacket dispatch,
    input  logic                       resultValid,
    input  dispatchPkg::resultMsg      result,
    output logic                       commitValid,
    output dispatchPkg::commitMsg      commit
);

    logic            allocEn;
    archPkg::regName allocDest;
    archPkg::robTag  allocTag;
    logic            robFull;

    regFile uRegFile (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .issueReq      (issueReq),
        .issueInst     (issueInst),
        .issueAck      (issueAck),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .robFull       (robFull),
        .allocTag      (allocTag),
        .allocEn       (allocEn),
        .allocDest     (allocDest),
        .commitValid   (commitValid),
        .commit        (commit)
    );

    reorderBuffer uRob (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .allocEn     (allocEn),
        .allocDest   (allocDest),
        .allocTag    (allocTag),
        .robFull     (robFull),
        .resultValid (resultValid),
        .result      (result),
        .commitValid (commitValid),
        .commit      (commit)
    );

endmodule

// ==== renameCore_tb.sv ====
`timescale 1ns/1ps
`include "renameCore_defs.svh"

module renameCore_tb;

    localparam int TIMEOUT = 60;
    // Cycle budgets of reset, rename, order, tag match, back-pressure and flush tests
    localparam int BUDGET = 400 + 200 + 200 + 250 + 300 + 200;

    logic clk = 1'b0;
    logic rst, flush, issueReq, issueAck;
    logic dispatchValid, resultValid, commitValid;
    dispatchPkg::decodedInst    issueInst;
    dispatchPkg::dispatchPacket dispatch;
    dispatchPkg::resultMsg      result;
    dispatchPkg::commitMsg      commit;

    // Reference model of the register table and the ROB queue
    archPkg::dataWord modelData [`REG_NUM] = '{default: '0};
    archPkg::robTag   modelTag [`REG_NUM] = '{default: '0};
    archPkg::regName  pendDest [`ROB_DEPTH+1];
    archPkg::dataWord pendData [`ROB_DEPTH+1];
    logic             resultSent [`ROB_DEPTH+1] = '{default: 1'b0};
    archPkg::robTag   robQ [$];
    archPkg::robTag   nextTag = 1;
    logic [31:0]      rngState = 32'h01c9b8d2;
    int               errCount = 0;
    int               testErrs = 0;
    int               testsRun = 0;
    int               testsFailed = 0;
    string            curTest = "setup";

    renameCore u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic checkVal(string what, logic [191:0] expected, logic [191:0] actual);
        if (expected !== actual) begin
            errCount++;
            $display("[FAIL] %s: %s expected %0h actual %0h", curTest, what, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic abortRun(string why);
        errCount++;
        $display("%s: %s", curTest, why);
        finishRun();
    endtask

    task automatic beginTest(string name);
        curTest  = name;
        testErrs = errCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errCount != testErrs) begin
            testsFailed++;
        end
        $display("test %s finished with %0d errors", curTest, errCount - testErrs);
    endtask

    task automatic issue(archPkg::opCode opc, archPkg::regName rd, archPkg::regName rs1,
                         archPkg::regName rs2, output dispatchPkg::dispatchPacket got);
        dispatchPkg::dispatchPacket exp;
        int waitCyc = 0;
        exp.inst = '{op: opc, rs1: rs1, rs2: rs2, rd: rd, pc: xorshift(),
                     imm: xorshift(), predTaken: 1'b0};
        exp.rs1Data = modelData[rs1];
        exp.rs1Tag  = modelTag[rs1];
        exp.rs2Data = modelData[rs2];
        exp.rs2Tag  = modelTag[rs2];
        exp.tag     = nextTag;
        // Stores rename nothing, and rd of 0 already gives dest 0
        exp.dest    = (opc inside {archPkg::OP_SB, archPkg::OP_SH, archPkg::OP_SW}) ? '0 : rd;
        checkVal("issueAck low before request", 0, issueAck);
        @(posedge clk);
        issueReq  <= 1'b1;
        issueInst <= exp.inst;
        do begin
            @(negedge clk);
            waitCyc++;
        end while (!issueAck && waitCyc < TIMEOUT);
        if (!issueAck) begin
            abortRun("issueAck never rose for a pending request");
        end else begin
            got = dispatch;
            checkVal("dispatchValid on accept", 1, dispatchValid);
            checkVal("dispatch packet", exp, dispatch);
            if (exp.dest != '0) begin
                modelTag[exp.dest] = exp.tag;
            end
            pendDest[exp.tag]   = exp.dest;
            resultSent[exp.tag] = 1'b0;
            robQ.push_back(exp.tag);
            nextTag = (nextTag == `ROB_DEPTH) ? archPkg::robTag'(1) : archPkg::robTag'(nextTag + 1);
            @(posedge clk);
            issueReq <= 1'b0;
            @(negedge clk);
            checkVal("dispatchValid lasts one cycle", 0, dispatchValid);
            checkVal("issueAck held until issueReq falls", 1, issueAck);
            waitCyc = 0;
            while (issueAck && waitCyc < TIMEOUT) begin
                @(negedge clk);
                waitCyc++;
            end
            if (issueAck) begin
                abortRun("issueAck stayed high after issueReq fell");
            end
        end
    endtask

    task automatic sendResult(archPkg::robTag tag);
        pendData[tag]   = xorshift();
        resultSent[tag] = 1'b1;
        @(posedge clk);
        resultValid <= 1'b1;
        result      <= '{tag: tag, data: pendData[tag]};
        @(posedge clk);
        resultValid <= 1'b0;
    endtask

    task automatic waitQueue(int left);
        int waitCyc = 0;
        while (robQ.size() > left && waitCyc < TIMEOUT) begin
            @(negedge clk);
            waitCyc++;
        end
        if (robQ.size() > left) begin
            abortRun("reorder buffer stopped committing finished entries");
        end
    endtask

    task automatic drain();
        archPkg::robTag pending [$];
        pending = robQ;
        foreach (pending[i]) begin
            if (!resultSent[pending[i]]) begin
                sendResult(pending[i]);
            end
        end
        waitQueue(0);
    endtask

    // Lookup through a store, then retire everything
    task automatic lookup(archPkg::regName rs1, archPkg::regName rs2,
                          output dispatchPkg::dispatchPacket got);
        issue(archPkg::OP_SW, 5'd0, rs1, rs2, got);
        drain();
    endtask

    // Commits must follow allocation order; model table follows tag-matched writes
    always @(negedge clk) begin : commitMonitor
        archPkg::robTag  expTag;
        archPkg::regName d;
        if (!rst && commitValid) begin
            if (robQ.size() == 0) begin
                errCount++;
                $display("%s: commit of tag %0d with no entry pending", curTest, commit.tag);
            end else begin
                expTag = robQ.pop_front();
                d      = pendDest[expTag];
                checkVal("commit only after its result", 1, resultSent[expTag]);
                checkVal("commit", {d, expTag, pendData[expTag]}, commit);
                if (d != '0 && modelTag[d] == expTag) begin
                    modelData[d] = pendData[expTag];
                    modelTag[d]  = '0;
                end
            end
        end
    end

    task automatic testReset();
        dispatchPkg::dispatchPacket p;
        beginTest("reset");
        checkVal("outputs low after reset", 0, {issueAck, dispatchValid, commitValid});
        for (int r = 0; r < `REG_NUM; r += 2) begin
            lookup(archPkg::regName'(r), archPkg::regName'(r + 1), p);
        end
        endTest();
    endtask

    task automatic testRename();
        dispatchPkg::dispatchPacket p1, p2, p;
        archPkg::robTag t1;
        archPkg::robTag t2;
        beginTest("rename");
        t1 = nextTag;
        t2 = archPkg::robTag'(t1 % `ROB_DEPTH + 1);
        issue(archPkg::OP_ADD, 5'd7, 5'd1, 5'd2, p1);
        issue(archPkg::OP_ADDI, 5'd7, 5'd7, 5'd0, p2);
        checkVal("first writer tag", t1, p1.tag);
        checkVal("own rd as source sees previous tag", t1, p2.rs1Tag);
        checkVal("successive tags", t2, p2.tag);
        issue(archPkg::OP_SW, 5'd7, 5'd7, 5'd0, p);
        checkVal("reader sees newest tag", t2, p.rs1Tag);
        issue(archPkg::OP_ADDI, 5'd0, 5'd7, 5'd0, p);
        checkVal("x0 writer renames nothing", 0, p.dest);
        lookup(5'd7, 5'd0, p);
        checkVal("r7 keeps newest tag", t2, p.rs1Tag);
        endTest();
    endtask

    task automatic testOrder();
        archPkg::regName rd [4];
        dispatchPkg::dispatchPacket p [4];
        dispatchPkg::dispatchPacket q;
        beginTest("order");
        for (int i = 0; i < 4; i++) begin
            rd[i] = archPkg::regName'(xorshift() % 31 + 1);
            issue(archPkg::OP_ADD, rd[i], archPkg::regName'(xorshift()), 5'd3, p[i]);
        end
        // Youngest result first
        for (int i = 3; i >= 0; i--) begin
            sendResult(p[i].tag);
        end
        drain();
        lookup(rd[0], rd[1], q);
        lookup(rd[2], rd[3], q);
        endTest();
    endtask

    task automatic testTagMatch();
        dispatchPkg::dispatchPacket w1, w2, p;
        archPkg::dataWord oldData;
        archPkg::dataWord newData;
        archPkg::robTag   newTag;
        beginTest("tag match");
        oldData = modelData[9];
        issue(archPkg::OP_ADD, 5'd9, 5'd1, 5'd2, w1);
        newTag = nextTag;
        issue(archPkg::OP_ADD, 5'd9, 5'd1, 5'd2, w2);
        sendResult(w1.tag);
        waitQueue(1);
        issue(archPkg::OP_SW, 5'd0, 5'd9, 5'd0, p);
        checkVal("older commit leaves data", oldData, p.rs1Data);
        checkVal("newer tag remains", newTag, p.rs1Tag);
        // Finished but blocked behind the newer writer
        sendResult(p.tag);
        sendResult(w2.tag);
        newData = pendData[w2.tag];
        drain();
        lookup(5'd9, 5'd0, p);
        checkVal("newest data and tag after commit", {newData, 3'd0}, {p.rs1Data, p.rs1Tag});
        endTest();
    endtask

    task automatic testBackPressure();
        dispatchPkg::dispatchPacket w [`ROB_DEPTH];
        dispatchPkg::dispatchPacket p;
        beginTest("back-pressure");
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            issue(archPkg::OP_LW, archPkg::regName'(10 + i), 5'd1, 5'd0, w[i]);
        end
        fork
            // Sources stay clear of r10, which the head commit updates
            issue(archPkg::OP_SW, 5'd0, 5'd20, 5'd21, p);
            begin
                repeat (6) begin
                    @(negedge clk);
                    checkVal("issueAck withheld while full", 0, issueAck);
                end
                sendResult(w[0].tag);
            end
        join
        drain();
        endTest();
    endtask

    task automatic testFlush();
        dispatchPkg::dispatchPacket p, q;
        archPkg::dataWord kept;
        beginTest("flush");
        issue(archPkg::OP_ADD, 5'd5, 5'd1, 5'd2, p);
        drain();
        kept = modelData[5];
        issue(archPkg::OP_ADD, 5'd5, 5'd3, 5'd4, p);
        issue(archPkg::OP_ADD, 5'd6, 5'd5, 5'd4, q);
        // The younger entry finishes first and waits behind the older one
        sendResult(q.tag);
        @(posedge clk);
        flush       <= 1'b1;
        resultValid <= 1'b1;
        // The older entry finishes on the flush edge itself
        result      <= '{tag: p.tag, data: xorshift()};
        @(posedge clk);
        flush       <= 1'b0;
        resultValid <= 1'b0;
        robQ.delete();
        modelTag = '{default: '0};
        nextTag  = 1;
        // The ROB is empty now, so no commit may follow
        repeat (8) @(negedge clk);
        checkVal("outputs low after flush", 0, {issueAck, dispatchValid, commitValid});
        lookup(5'd5, 5'd6, p);
        checkVal("committed data survives flush", kept, p.rs1Data);
        checkVal("tags cleared by flush", 0, {p.rs1Tag, p.rs2Tag});
        checkVal("first tag after flush", 1, p.tag);
        endTest();
    endtask

    // Twice the summed budgets at 4 ns per cycle
    initial begin
        #(2 * BUDGET * 4);
        abortRun("watchdog timer expired before all tests completed");
    end

    initial begin
        rst         <= 1'b1;
        flush       <= 1'b0;
        issueReq    <= 1'b0;
        issueInst   <= '0;
        resultValid <= 1'b0;
        result      <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        testReset();
        testRename();
        testOrder();
        testTagMatch();
        testBackPressure();
        testFlush();
        finishRun();
    end

endmodule

// ==== renameCore.f ====
+incdir+.
archPkg.sv
dispatchPkg.sv
regFile.sv
reorderBuffer.sv
renameCore.sv
renameCore_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= renameCore_tb
FILELIST   ?= renameCore.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
